// File: common/coreTypes.sv
// Shared widths and encodings for the RV32 OP/OP-IMM core; pc counts instructions, not bytes
package coreTypes;

    localparam int XLEN     = 32;               // Data path width
    localparam int RegAddrW = 5;                // 32 general registers
    localparam int ShamtW   = 5;                // Shift amount width for XLEN 32

    typedef logic [XLEN-1:0]     dataT;         // Register or ALU value
    typedef logic [RegAddrW-1:0] regAddrT;      // Register index
    typedef logic [31:0]         pcT;           // Instruction counter
    typedef logic [31:0]         instrT;        // Raw instruction word
    typedef logic [ShamtW-1:0]   shamtT;        // Shift amount

    // Instruction field positions
    localparam int OpcodeLsb = 0;
    localparam int OpcodeW   = 7;
    localparam int RdLsb     = 7;
    localparam int Funct3Lsb = 12;
    localparam int Rs1Lsb    = 15;
    localparam int Rs2Lsb    = 20;
    localparam int Funct7Lsb = 25;
    localparam int ImmLsb    = 20;              // I-type immediate, also shamt on shifts
    localparam int ImmW      = 12;

    localparam logic [6:0] Funct7Base = 7'b0000000;
    localparam logic [6:0] Funct7Alt  = 7'b0100000;   // sub, sra, srai

    // Supported major opcodes
    typedef enum logic [6:0] {
        OpImm = 7'b0010011,
        OpReg = 7'b0110011
    } opcodeT;

    typedef enum logic [3:0] {
        AluAdd, AluSub, AluSll, AluSlt, AluSltu,
        AluXor, AluSrl, AluSra, AluOr,  AluAnd
    } aluOpT;

    // Sequencer FSM
    typedef enum logic [1:0] {
        SeqIdle,
        SeqRead,
        SeqExec,
        SeqWrite
    } seqStateT;

endpackage

// File: common/aluIf.sv
// Start/done link to the ALU; op, a and b must stay stable from start until done
interface aluIf;
    import coreTypes::*;

    logic  start;       // One-cycle request
    aluOpT op;
    dataT  a;
    dataT  b;           // Low bits are the shift amount on shifts
    logic  done;        // One-cycle completion, once per start
    dataT  result;      // Held until the next start

    // Sequencer side
    modport master (
        output start, op, a, b,
        input  done, result
    );

    // ALU side
    modport slave (
        input  start, op, a, b,
        output done, result
    );

endinterface

// File: design/instrDecoder.sv
// Combinational decode of OP and OP-IMM only; every other opcode is flagged illegal
module instrDecoder (
    input  coreTypes::instrT   instr,
    output coreTypes::regAddrT rs1,
    output coreTypes::regAddrT rs2,
    output coreTypes::regAddrT rd,
    output coreTypes::aluOpT   aluOp,
    output logic               useImm,
    output coreTypes::dataT    imm,
    output logic               illegal
);
    import coreTypes::*;

    opcodeT     opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    shamtT      shamt;
    logic       isShift;
    logic       f7Base;     // funct7 all zero
    logic       f7AltOk;    // funct7 zero or the alternate encoding

    assign opcode  = opcodeT'(instr[OpcodeLsb +: OpcodeW]);
    assign funct3  = instr[Funct3Lsb +: 3];
    assign funct7  = instr[Funct7Lsb +: 7];
    assign shamt   = instr[ImmLsb +: ShamtW];
    assign rs1     = instr[Rs1Lsb +: RegAddrW];
    assign rs2     = instr[Rs2Lsb +: RegAddrW];
    assign rd      = instr[RdLsb +: RegAddrW];
    assign useImm  = (opcode == OpImm);
    assign isShift = (funct3 == 3'b001) || (funct3 == 3'b101);
    assign f7Base  = (funct7 == Funct7Base);
    assign f7AltOk = f7Base || (funct7 == Funct7Alt);

    // Shifts take a zero-extended shamt, the rest a sign-extended imm12
    assign imm = isShift ? {{(XLEN-ShamtW){1'b0}}, shamt}
                         : {{(XLEN-ImmW){instr[31]}}, instr[ImmLsb +: ImmW]};

    always_comb
    begin
        case (funct3)
            3'b000:  aluOp = (opcode == OpReg && funct7 == Funct7Alt) ? AluSub : AluAdd;
            3'b001:  aluOp = AluSll;
            3'b010:  aluOp = AluSlt;
            3'b011:  aluOp = AluSltu;
            3'b100:  aluOp = AluXor;
            3'b101:  aluOp = (funct7 == Funct7Alt) ? AluSra : AluSrl;   // Bit 30 picks sra
            3'b110:  aluOp = AluOr;
            default: aluOp = AluAnd;
        endcase
    end

    always_comb
    begin
        case (opcode)
            OpImm:   illegal = (funct3 == 3'b001) ? !f7Base :
                               (funct3 == 3'b101) ? !f7AltOk : 1'b0;    // Only shifts check funct7
            OpReg:   illegal = (funct3 == 3'b000 || funct3 == 3'b101) ? !f7AltOk : !f7Base;
            default: illegal = 1'b1;                                     // Loads, stores, lui...
        endcase
    end

endmodule

// File: design/regFile.sv
// Two combinational read ports, one write port on the clock edge; x0 always reads zero
module regFile (
    input  logic               clk,
    input  logic               reset,
    input  coreTypes::regAddrT raddr1,
    input  coreTypes::regAddrT raddr2,
    output coreTypes::dataT    rdata1,
    output coreTypes::dataT    rdata2,
    input  logic               we,
    input  coreTypes::regAddrT waddr,
    input  coreTypes::dataT    wdata
);
    import coreTypes::*;

    localparam int NumRegs = 2 ** RegAddrW;

    dataT regs [NumRegs];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < NumRegs; i++)
                regs[i] <= '0;              // Whole file reads zero after reset
        end
        else if (we && waddr != '0)         // x0 never written
        begin
            regs[waddr] <= wdata;
        end
    end

    // Read x0 as constant zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: alu/alu.sv
// One-cycle ALU with a serial shifter, one bit per cycle; start is ignored while a shift runs
module alu (
    input logic clk,
    input logic reset,
    aluIf.slave bus
);
    import coreTypes::*;

    logic  running;     // Serial shift in progress
    shamtT count;       // Shift steps left
    shamtT shamt;
    logic  isShift;
    dataT  quick;       // Single-cycle result
    dataT  stepVal;     // Result after one more shift step

    assign shamt   = bus.b[ShamtW-1:0];        // Only low bits of b count
    assign isShift = (bus.op == AluSll) || (bus.op == AluSrl) || (bus.op == AluSra);

    always_comb
    begin
        case (bus.op)
            AluAdd:  quick = bus.a + bus.b;
            AluSub:  quick = bus.a - bus.b;
            AluSlt:  quick = {{(XLEN-1){1'b0}}, $signed(bus.a) < $signed(bus.b)};
            AluSltu: quick = {{(XLEN-1){1'b0}}, bus.a < bus.b};
            AluXor:  quick = bus.a ^ bus.b;
            AluOr:   quick = bus.a | bus.b;
            AluAnd:  quick = bus.a & bus.b;
            default: quick = bus.a;             // Shifts start from a
        endcase
    end

    // One shift position; op stays stable while running
    always_comb
    begin
        case (bus.op)
            AluSll:  stepVal = {bus.result[XLEN-2:0], 1'b0};
            AluSra:  stepVal = {bus.result[XLEN-1], bus.result[XLEN-1:1]};   // Keep sign
            default: stepVal = {1'b0, bus.result[XLEN-1:1]};
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            running  <= 1'b0;
            count    <= '0;
            bus.done <= 1'b0;
        end
        else
        begin
            bus.done <= 1'b0;                   // Pulse
            if (running)
            begin
                count <= count - 1'b1;
                if (count == shamtT'(1))        // Last step
                begin
                    running  <= 1'b0;
                    bus.done <= 1'b1;
                end
            end
            else if (bus.start)
            begin
                if (isShift && shamt != '0)
                begin
                    running <= 1'b1;
                    count   <= shamt;
                end
                else
                    bus.done <= 1'b1;           // Ready one cycle after start
            end
        end
    end

    // Result doubles as the shift register
    always_ff @(posedge clk)
    begin
        if (running)
            bus.result <= stepVal;
        else if (bus.start)
            bus.result <= quick;
    end

endmodule

// File: design/sequencer.sv
// One instruction in flight; instrValid is only taken in SeqIdle, latency ends with rdValid
module sequencer #(
    parameter coreTypes::pcT ResetPc = '0
) (
    input  logic               clk,
    input  logic               reset,
    input  coreTypes::instrT   instr,
    input  logic               instrValid,
    output logic               busy,
    output coreTypes::pcT      pc,
    output logic               rdValid,
    output coreTypes::regAddrT rdAddr,
    output coreTypes::dataT    rdData,
    output logic               illegalInstr,
    output coreTypes::instrT   instrReg,        // Feeds the decoder
    input  coreTypes::regAddrT rs1,
    input  coreTypes::regAddrT rs2,
    input  coreTypes::regAddrT rd,
    input  coreTypes::aluOpT   aluOp,
    input  logic               useImm,
    input  coreTypes::dataT    imm,
    input  logic               illegal,
    output coreTypes::regAddrT raddr1,
    output coreTypes::regAddrT raddr2,
    input  coreTypes::dataT    rdata1,
    input  coreTypes::dataT    rdata2,
    output logic               we,
    output coreTypes::regAddrT waddr,
    output coreTypes::dataT    wdata,
    aluIf.master               alu
);
    import coreTypes::*;

    seqStateT state;
    regAddrT  rdQ;      // Destination held until write-back

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state        <= SeqIdle;
            pc           <= ResetPc;
            alu.start    <= 1'b0;
            illegalInstr <= 1'b0;
        end
        else
        begin
            alu.start    <= 1'b0;               // Both are pulses
            illegalInstr <= 1'b0;
            case (state)
                SeqIdle:  if (instrValid) state <= SeqRead;
                SeqRead:
                begin
                    if (illegal)                // Skip, pc unchanged
                    begin
                        state        <= SeqIdle;
                        illegalInstr <= 1'b1;
                    end
                    else
                    begin
                        state     <= SeqExec;
                        alu.start <= 1'b1;
                    end
                end
                SeqExec:  if (alu.done) state <= SeqWrite;
                SeqWrite:
                begin
                    state <= SeqIdle;
                    pc    <= pc + 1'b1;         // One step per instruction
                end
                default:  state <= SeqIdle;
            endcase
        end
    end

    // Instruction and operand latches
    always_ff @(posedge clk)
    begin
        if (state == SeqIdle && instrValid)
            instrReg <= instr;
        if (state == SeqRead)
        begin
            rdQ   <= rd;
            alu.op <= aluOp;
            alu.a <= rdata1;
            alu.b <= useImm ? imm : rdata2;     // Immediate or rs2
        end
    end

    assign busy    = (state != SeqIdle);
    assign raddr1  = rs1;
    assign raddr2  = rs2;
    assign rdValid = (state == SeqWrite);
    assign rdAddr  = rdQ;
    assign rdData  = alu.result;                // ALU holds it past done
    assign we      = rdValid && (rdQ != '0);   // Result still reported for x0
    assign waddr   = rdQ;
    assign wdata   = alu.result;

endmodule

// File: design/aluCore.sv
// Multi-cycle RV32 OP/OP-IMM execution core; no queue, instrValid while busy is dropped
module aluCore #(
    parameter coreTypes::pcT ResetPc = '0
) (
    input  logic               clk,
    input  logic               reset,
    input  coreTypes::instrT   instr,
    input  logic               instrValid,
    output logic               busy,
    output coreTypes::pcT      pc,
    output logic               rdValid,
    output coreTypes::regAddrT rdAddr,
    output coreTypes::dataT    rdData,
    output logic               illegalInstr
);
    import coreTypes::*;

    instrT   instrReg;
    regAddrT rs1, rs2, rd;
    aluOpT   aluOp;
    logic    useImm;
    dataT    imm;
    logic    illegal;
    regAddrT raddr1, raddr2, waddr;
    dataT    rdata1, rdata2, wdata;
    logic    we;

    aluIf aluBus ();

    instrDecoder uDecoder (
        .instr   (instrReg),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .aluOp   (aluOp),
        .useImm  (useImm),
        .imm     (imm),
        .illegal (illegal)
    );

    regFile uRegFile (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (we),
        .waddr  (waddr),
        .wdata  (wdata)
    );

    alu uAlu (
        .clk   (clk),
        .reset (reset),
        .bus   (aluBus.slave)
    );

    sequencer #(
        .ResetPc (ResetPc)
    ) uSequencer (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .instrValid   (instrValid),
        .busy         (busy),
        .pc           (pc),
        .rdValid      (rdValid),
        .rdAddr       (rdAddr),
        .rdData       (rdData),
        .illegalInstr (illegalInstr),
        .instrReg     (instrReg),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .aluOp        (aluOp),
        .useImm       (useImm),
        .imm          (imm),
        .illegal      (illegal),
        .raddr1       (raddr1),
        .raddr2       (raddr2),
        .rdata1       (rdata1),
        .rdata2       (rdata2),
        .we           (we),
        .waddr        (waddr),
        .wdata        (wdata),
        .alu          (aluBus.master)
    );

endmodule

// File: sim/aluCore_assert.sv
// Protocol checks bound into every sequencer instance; the pc check expects one step per rdValid
module seqAssert (
    input logic                clk,
    input logic                reset,
    input coreTypes::seqStateT state,
    input logic                rdValid,
    input logic                illegalInstr,
    input logic                start,
    input coreTypes::pcT       pc
);
    import coreTypes::*;

    // A completion is either a result or an illegal skip
    onlyOneCompletion: assert property (@(posedge clk) disable iff (reset)
        !(rdValid && illegalInstr))
        else $error("rdValid and illegalInstr high in the same cycle");

    startInExec: assert property (@(posedge clk) disable iff (reset)
        start |-> (state == SeqExec))           // Registered pulse lands in SeqExec
        else $error("ALU start outside SeqExec");

    pcAfterResult: assert property (@(posedge clk) disable iff (reset)
        (pc != $past(pc)) |-> $past(rdValid))
        else $error("pc moved without a preceding rdValid");

endmodule

bind sequencer seqAssert seqAssert_i (
    .clk          (clk),
    .reset        (reset),
    .state        (state),
    .rdValid      (rdValid),
    .illegalInstr (illegalInstr),
    .start        (alu.start),
    .pc           (pc)
);

// File: sim/tb_aluCore.sv
// Self-checking testbench; one instruction in flight, expected results come from a shadow register file
module tb_aluCore;
    import coreTypes::*;

    localparam int NumLoad  = 31;               // addi x1..x31 from x0
    localparam int NumImm   = 45;
    localparam int NumReg   = 50;
    localparam int NumFixed = 13;               // x0, sra, held and illegal cases
    localparam int NumInstr = NumLoad + NumImm + NumReg + NumFixed;

    logic    clk;
    logic    reset;
    instrT   instr;
    logic    instrValid;
    logic    busy;
    pcT      pc;
    logic    rdValid;
    regAddrT rdAddr;
    dataT    rdData;
    logic    illegalInstr;

    dataT    shadow [32];                       // Architectural view of the register file
    pcT      nextPc;
    string   expName [$];
    logic    expIll [$];
    regAddrT expAddr [$];
    dataT    expData [$];
    pcT      expPc [$];

    aluCore #(.ResetPc('0)) dut_i (.*);

    always #10 clk = ~clk;

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic checkData(input string name, input dataT exp, input dataT act);
        if (act !== exp)
            failRun($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic checkAddr(input string name, input regAddrT exp, input regAddrT act);
        if (act !== exp)
            failRun($sformatf("** Error %s: expected x%0d, actual x%0d", name, exp, act));
    endtask

    task automatic checkPc(input string name, input pcT exp, input pcT act);
        if (act !== exp)
            failRun($sformatf("** Error %s: expected pc %0d, actual pc %0d", name, exp, act));
    endtask

    function automatic instrT encI(input logic [2:0] f3, input regAddrT rd, input regAddrT rs1,
                                   input logic [11:0] imm);
        encI = {imm, rs1, f3, rd, OpImm};
    endfunction

    function automatic instrT encR(input logic [6:0] f7, input logic [2:0] f3, input regAddrT rd,
                                   input regAddrT rs1, input regAddrT rs2);
        encR = {f7, rs2, rs1, f3, rd, OpReg};
    endfunction

    // RV32I semantics of OP and OP-IMM on the shadow registers
    function automatic dataT refResult(input instrT w);
        dataT a;
        dataT b;
        logic isImm;
        isImm = (w[6:0] == OpImm);
        a     = shadow[w[19:15]];
        b     = isImm ? {{20{w[31]}}, w[31:20]} : shadow[w[24:20]];
        case (w[14:12])
            3'd0:    refResult = (!isImm && w[30]) ? a - b : a + b;
            3'd1:    refResult = a << b[4:0];
            3'd2:    refResult = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    refResult = (a < b) ? 32'd1 : 32'd0;
            3'd4:    refResult = a ^ b;
            3'd5:    refResult = w[30] ? dataT'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    refResult = a | b;
            default: refResult = a & b;
        endcase
    endfunction

    // Queue the expectation, then present the word once the core is idle
    task automatic issue(input string name, input instrT word, input logic hold);
        logic legal;
        dataT value;
        legal = (word[6:0] == OpImm) || (word[6:0] == OpReg);
        value = legal ? refResult(word) : '0;
        expName.push_back(name);
        expIll.push_back(!legal);
        expAddr.push_back(word[11:7]);
        expData.push_back(value);
        expPc.push_back(nextPc);
        if (legal && word[11:7] != '0)
            shadow[word[11:7]] = value;         // x0 stays zero
        if (legal)
            nextPc++;
        do @(posedge clk); while (busy);
        instr      <= word;
        instrValid <= 1'b1;
        @(posedge clk);                         // Accepted here
        if (hold)
        begin
            instr <= ~word;                     // Illegal junk that the busy core must ignore
            @(posedge clk);
            @(posedge clk);
        end
        instrValid <= 1'b0;
    endtask

    // Compare every result or illegal pulse with the oldest expectation
    always @(posedge clk)
    begin : compareResults
        string name;
        if (!reset && (rdValid || illegalInstr))
        begin
            if (expName.size() == 0)
                failRun("Core reported a result with no instruction outstanding");
            else
            begin
                name = expName.pop_front();
                if (rdValid == expIll[0] || illegalInstr != expIll[0])
                    failRun({"Wrong kind of completion (result vs illegal) for ", name});
                else if (rdValid)
                begin
                    checkAddr(name, expAddr[0], rdAddr);
                    checkData(name, expData[0], rdData);
                end
                checkPc(name, expPc[0], pc);    // Unchanged pc on illegal
                void'(expIll.pop_front());
                void'(expAddr.pop_front());
                void'(expData.pop_front());
                void'(expPc.pop_front());
            end
        end
    end

    initial
    begin
        #((NumInstr * 60 + 16) * 20);
        failRun("Watchdog expired before all instructions completed");
    end

    initial
    begin : mainFlow
        int         k;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm12;
        void'($urandom(64));
        clk        = 1'b0;
        reset      = 1'b1;
        instr      = '0;
        instrValid = 1'b0;
        nextPc     = '0;
        for (int i = 0; i < 32; i++)
            shadow[i] = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        if (busy || rdValid || illegalInstr)
            failRun("busy, rdValid or illegalInstr not low after reset");
        else
            checkPc("reset pc", '0, pc);

        for (int i = 1; i <= NumLoad; i++)      // Mixed-sign register contents
            issue($sformatf("load x%0d", i), encI(3'd0, regAddrT'(i), '0, 12'($urandom())), 1'b0);

        for (int i = 0; i < NumImm; i++)        // All nine OP-IMM operations in turn
        begin
            k     = i % 9;
            f3    = 3'((k < 6) ? k : k - 1);    // Slot 6 is srai
            imm12 = 12'($urandom());
            if (f3 == 3'd1 || f3 == 3'd5)
                imm12 = {(k == 6) ? Funct7Alt : Funct7Base, 5'($urandom())};
            issue($sformatf("opimm %0d f3 %0d", i, f3),
                  encI(f3, regAddrT'($urandom_range(31, 1)), regAddrT'($urandom_range(31, 0)),
                       imm12), 1'b0);
        end

        for (int i = 0; i < NumReg; i++)        // All ten OP operations in turn
        begin
            k  = i % 10;
            f3 = 3'((k == 0) ? 0 : (k < 7) ? k - 1 : k - 2);
            f7 = (k == 1 || k == 7) ? Funct7Alt : Funct7Base;   // sub, sra
            issue($sformatf("op %0d f3 %0d", i, f3),
                  encR(f7, f3, regAddrT'($urandom_range(31, 1)), regAddrT'($urandom_range(31, 0)),
                       regAddrT'($urandom_range(31, 0))), 1'b0);
        end

        issue("addi to x0", encI(3'd0, 5'd0, 5'd5, 12'd123), 1'b0);
        issue("add x0 x0", encR(Funct7Base, 3'd0, 5'd7, 5'd0, 5'd0), 1'b0);
        issue("add x0 x6", encR(Funct7Base, 3'd0, 5'd8, 5'd0, 5'd6), 1'b0);
        issue("load -8", encI(3'd0, 5'd9, 5'd0, 12'hff8), 1'b0);
        issue("load 3", encI(3'd0, 5'd11, 5'd0, 12'd3), 1'b0);
        issue("sra negative", encR(Funct7Alt, 3'd5, 5'd10, 5'd9, 5'd11), 1'b0);
        issue("slt negative", encR(Funct7Base, 3'd2, 5'd12, 5'd9, 5'd11), 1'b0);
        issue("sltu negative", encR(Funct7Base, 3'd3, 5'd13, 5'd9, 5'd11), 1'b0);

        issue("held add", encR(Funct7Base, 3'd0, 5'd14, 5'd1, 5'd2), 1'b1);
        issue("held srli", encI(3'd5, 5'd15, 5'd3, 12'd7), 1'b1);
        issue("held xor", encR(Funct7Base, 3'd4, 5'd16, 5'd14, 5'd15), 1'b1);

        issue("lui illegal", 32'h1234_5537, 1'b0);
        issue("lw illegal", 32'h0000_2083, 1'b0);

        while (expName.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);              // Room for any stray completion
        checkPc("final pc", nextPc, pc);
        if (!busy)
        begin
            $display("Simulation passed");
            $finish;
        end
        else
            failRun("Core still busy after the last instruction completed");
    end

endmodule

// File: vlog.f
common/coreTypes.sv
common/aluIf.sv
design/instrDecoder.sv
design/regFile.sv
alu/alu.sv
design/sequencer.sv
design/aluCore.sv
sim/aluCore_assert.sv
sim/tb_aluCore.sv

// File: run.sh
#!/usr/bin/env bash
# Compile with Verilator, run, and judge the run by the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_aluCore -Mdir obj_dir -f vlog.f \
    && ./obj_dir/Vtb_aluCore 2>&1 | tee sim.log \
    || { echo "Build or simulation run failed"; exit 1; }
grep -q "Simulation failed" sim.log && exit 1 || exit 0
